/* Makefile */
# Verilator build and run for the accelerator shell testbench

SIM  := obj_dir/Vtb_shell
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_shell -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* source/apb_cfg_regs.sv */
//////////////////////////////////////////////////////////////////////
// APB configuration registers
// Base address, software start bit and read-only busy status
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_cfg_regs
   import shell_pkg::*;
(
   input  logic              clk,
   input  logic              reset_pe,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output logic              start,
   output logic [ADDR_W-1:0] base_addr,
   input  logic              core_reset,
   input  logic              kernel_busy,
   output logic              busy
);

   logic              setup_ph;
   logic              wr_en;
   logic              mapped;
   logic [DATA_W-1:0] rd_mux;

   assign setup_ph = psel && !penable;
   assign wr_en    = psel && penable && pwrite;   // Access phase of a write
   assign pready   = 1'b1;
   assign busy     = core_reset || kernel_busy;

   // Register map decode
   always_comb begin
      rd_mux = '0;
      mapped = 1'b1;
      case (paddr[7:0])
         REG_BASE:  rd_mux = base_addr;
         REG_START: rd_mux = {{(DATA_W-1){1'b0}}, start};
         REG_BUSY:  rd_mux = {{(DATA_W-1){1'b0}}, busy};
         default:   mapped = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         base_addr <= '0;
         start     <= 1'b0;
         pslverr   <= 1'b0;
      end else begin
         if (wr_en && paddr[7:0] == REG_BASE)
            base_addr <= pwdata;
         if (wr_en && paddr[7:0] == REG_START)
            start <= pwdata[0];
         // High for the whole access phase only
         pslverr <= setup_ph && !mapped;
      end
   end

   // Read data captured in setup, held through access
   always_ff @(posedge clk) begin
      if (setup_ph && !pwrite)
         prdata <= rd_mux;
   end

   ///////////////////////////////////////////////////////////////////////
   // Protocol checks
   ///////////////////////////////////////////////////////////////////////

   a_penable_needs_psel : assert property (
      @(posedge clk) disable iff (reset_pe)
      penable |-> psel
   ) else $error("penable high without psel");

endmodule

/* source/axi_reloc_bridge.sv */
//////////////////////////////////////////////////////////////////////
// Relocation bridge
// Adds the base address and runs single-beat AXI reads and writes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axi_reloc_bridge
   import shell_pkg::*;
(
   input  logic              clk,
   input  logic              reset_pe,
   input  logic [ADDR_W-1:0] base_addr,
   mem_req_if.bridge         mem,
   output logic              awvalid,
   output logic [ADDR_W-1:0] awaddr,
   output logic              wvalid,
   output logic [DATA_W-1:0] wdata,
   output logic              bready,
   output logic              arvalid,
   output logic [ADDR_W-1:0] araddr,
   output logic              rready,
   input  logic              awready,
   input  logic              wready,
   input  logic              bvalid,
   input  logic              arready,
   input  logic              rvalid,
   input  logic [DATA_W-1:0] rdata
);

   logic              pending;    // Transaction open until its response
   logic              accept;
   mem_op_e           op_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;

   assign mem.req_ready = !pending;
   assign accept        = mem.req_valid && mem.req_ready;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         pending <= 1'b0;
         arvalid <= 1'b0;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end else begin
         // AW and W complete independently
         if (arvalid && arready) arvalid <= 1'b0;
         if (awvalid && awready) awvalid <= 1'b0;
         if (wvalid && wready)   wvalid  <= 1'b0;
         if (accept) begin
            pending <= 1'b1;
            if (mem.op == OP_READ) begin
               arvalid <= 1'b1;
            end else begin
               awvalid <= 1'b1;
               wvalid  <= 1'b1;
            end
         end else if (mem.done) begin
            pending <= 1'b0;
         end
      end
   end

   // Relocated request fields
   always_ff @(posedge clk) begin
      if (accept) begin
         op_q    <= mem.op;
         addr_q  <= base_addr + mem.rel_addr;
         wdata_q <= mem.wdata;
      end
   end

   assign araddr    = addr_q;
   assign awaddr    = addr_q;
   assign wdata     = wdata_q;
   assign rready    = pending && (op_q == OP_READ);
   assign bready    = pending && (op_q == OP_WRITE);
   assign mem.done  = (rvalid && rready) || (bvalid && bready);
   assign mem.rdata = rdata;

   a_aw_hold : assert property (
      @(posedge clk) disable iff (reset_pe)
      awvalid && !awready |=> awvalid && $stable(awaddr)
   ) else $error("awvalid dropped before awready");

endmodule

/* source/core_reset_seq.sv */
//////////////////////////////////////////////////////////////////////
// Core reset sequencer
// Holds the core in reset for a fixed time, then opens the run window
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_reset_seq
   import shell_pkg::*;
(
   input  logic clk,
   input  logic reset_pe,
   input  logic start,
   output logic core_reset,
   output logic run
);

   seq_state_e           state;
   logic [RST_CNT_W-1:0] hold_cnt;

   always_ff @(posedge clk) begin
      if (reset_pe) begin
         state    <= IDLE;
         hold_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               hold_cnt <= '0;
               if (start)
                  state <= HOLD;     // New start seen
            end
            HOLD: begin
               hold_cnt <= hold_cnt + 1'b1;
               if (hold_cnt == RST_CNT_W'(RESET_DELAY - 1))
                  state <= RUN;
            end
            RUN: begin
               if (!start)
                  state <= IDLE;     // Software stop
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign core_reset = (state == HOLD);
   assign run        = (state == RUN);

   // Reset window and run window never overlap
   a_no_overlap : assert property (
      @(posedge clk) disable iff (reset_pe)
      !(core_reset && run)
   ) else $error("core_reset and run high together");

   a_reset_len : assert property (
      @(posedge clk) disable iff (reset_pe)
      $rose(core_reset) |-> core_reset [*RESET_DELAY] ##1 !core_reset
   ) else $error("core_reset not held for RESET_DELAY cycles");

endmodule

/* source/incr_kernel.sv */
//////////////////////////////////////////////////////////////////////
// Increment kernel
// Reads WORD_COUNT words, adds one, writes them at OUT_OFFSET
// One memory request in flight at a time
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module incr_kernel
   import shell_pkg::*;
(
   input  logic      clk,
   input  logic      reset_pe,
   input  logic      core_reset,
   input  logic      run,
   mem_req_if.kernel mem,
   output logic      kernel_busy
);

   kern_state_e        state;
   logic [KIDX_W-1:0]  idx;
   logic [DATA_W-1:0]  result;
   logic [ADDR_W-1:0]  src_addr;
   logic               last_word;

   assign src_addr  = ADDR_W'({idx, 2'b00});   // Four bytes per word
   assign last_word = (idx == KIDX_W'(WORD_COUNT - 1));

   ///////////////////////////////////////////////////////////////////////
   // Control FSM
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_pe || core_reset) begin
         state <= K_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            K_IDLE: begin
               idx <= '0;
               if (run)
                  state <= K_READ;
            end
            K_READ: begin
               if (mem.req_ready)
                  state <= K_WAIT_R;
            end
            K_WAIT_R: begin
               if (mem.done)
                  state <= K_WRITE;
            end
            K_WRITE: begin
               if (mem.req_ready)
                  state <= K_WAIT_B;
            end
            K_WAIT_B: begin
               if (mem.done) begin
                  if (last_word) begin
                     state <= K_DONE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= K_READ;
                  end
               end
            end
            K_DONE: begin
               if (!run)
                  state <= K_IDLE;    // Wait for software to stop
            end
            default: state <= K_IDLE;
         endcase
      end
   end

   // Incremented word, held until the write is accepted
   always_ff @(posedge clk) begin
      if (state == K_WAIT_R && mem.done)
         result <= mem.rdata + 1'b1;
   end

   assign mem.req_valid = (state == K_READ) || (state == K_WRITE);
   assign mem.op        = (state == K_WRITE) ? OP_WRITE : OP_READ;
   assign mem.rel_addr  = (state == K_WRITE) ? src_addr + OUT_OFFSET : src_addr;
   assign mem.wdata     = result;

   assign kernel_busy = (state != K_IDLE) && (state != K_DONE);

   // Request held steady until the bridge takes it
   a_req_hold : assert property (
      @(posedge clk) disable iff (reset_pe || core_reset)
      mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.op)
         && $stable(mem.rel_addr) && $stable(mem.wdata)
   ) else $error("request dropped or changed before acceptance");

endmodule

/* source/mem_req_if.sv */
//////////////////////////////////////////////////////////////////////
// Kernel memory request channel
// One request at a time from the kernel to the AXI bridge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface mem_req_if
   import shell_pkg::*;
();

   // Request side, driven by the kernel
   logic              req_valid;
   mem_op_e           op;
   logic [ADDR_W-1:0] rel_addr;   // Relative to the base register
   logic [DATA_W-1:0] wdata;

   // Response side, driven by the bridge
   logic              req_ready;
   logic              done;       // R or B beat
   logic [DATA_W-1:0] rdata;      // Valid with done on reads

   modport kernel (
      output req_valid,
      output op,
      output rel_addr,
      output wdata,
      input  req_ready,
      input  done,
      input  rdata
   );

   modport bridge (
      input  req_valid,
      input  op,
      input  rel_addr,
      input  wdata,
      output req_ready,
      output done,
      output rdata
   );

endinterface

/* source/shell_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator shell shared definitions
// Bus widths, APB register map, core timing and state encodings
//////////////////////////////////////////////////////////////////////
package shell_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Fixed AXI attributes, single beat only
   localparam int         AXI_ID_W       = 4;
   localparam int         AXI_LEN_W      = 8;
   localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // APB register offsets, low address byte
   localparam logic [7:0] REG_BASE  = 8'h50;
   localparam logic [7:0] REG_START = 8'h54;
   localparam logic [7:0] REG_BUSY  = 8'h58;   // Read only

   // Core timing and job size
   localparam int RESET_DELAY = 12;
   localparam int RST_CNT_W   = $clog2(RESET_DELAY + 1);
   localparam int WORD_COUNT  = 8;
   localparam int KIDX_W      = $clog2(WORD_COUNT);
   localparam logic [ADDR_W-1:0] OUT_OFFSET = 32'h100;

   typedef enum logic [1:0] {
      IDLE,
      HOLD,    // Core held in reset
      RUN
   } seq_state_e;

   typedef enum logic [2:0] {
      K_IDLE,
      K_READ,
      K_WAIT_R,
      K_WRITE,
      K_WAIT_B,
      K_DONE
   } kern_state_e;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } mem_op_e;

endpackage

/* source/shell_top.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator shell top
// APB configuration in, relocated single-beat AXI master out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module shell_top
   import shell_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset_pe,
   // APB slave
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [ADDR_W-1:0]    paddr,
   input  logic [DATA_W-1:0]    pwdata,
   output logic [DATA_W-1:0]    prdata,
   output logic                 pready,
   output logic                 pslverr,
   // AXI write address and data
   output logic                 awvalid,
   output logic [ADDR_W-1:0]    awaddr,
   output logic [AXI_ID_W-1:0]  awid,
   output logic [AXI_LEN_W-1:0] awlen,
   output logic [2:0]           awsize,
   output logic [1:0]           awburst,
   input  logic                 awready,
   output logic                 wvalid,
   output logic [DATA_W-1:0]    wdata,
   output logic [STRB_W-1:0]    wstrb,
   output logic                 wlast,
   input  logic                 wready,
   // AXI write response
   input  logic                 bvalid,
   input  logic [1:0]           bresp,
   input  logic [AXI_ID_W-1:0]  bid,
   output logic                 bready,
   // AXI read address
   output logic                 arvalid,
   output logic [ADDR_W-1:0]    araddr,
   output logic [AXI_ID_W-1:0]  arid,
   output logic [AXI_LEN_W-1:0] arlen,
   output logic [2:0]           arsize,
   output logic [1:0]           arburst,
   input  logic                 arready,
   // AXI read data
   input  logic                 rvalid,
   input  logic [DATA_W-1:0]    rdata,
   input  logic [1:0]           rresp,
   input  logic                 rlast,
   input  logic [AXI_ID_W-1:0]  rid,
   output logic                 rready,
   output logic                 busy
);

   logic              start;
   logic [ADDR_W-1:0] base_addr;
   logic              core_reset;
   logic              run;
   logic              kernel_busy;

   mem_req_if mem_bus ();

   // Single beat, fixed id, full word
   assign awid    = '0;
   assign arid    = '0;
   assign awlen   = '0;
   assign arlen   = '0;
   assign awsize  = AXI_SIZE_4B;
   assign arsize  = AXI_SIZE_4B;
   assign awburst = AXI_BURST_INCR;
   assign arburst = AXI_BURST_INCR;
   assign wstrb   = '1;
   assign wlast   = 1'b1;

   apb_cfg_regs u_regs (
      .clk         (clk),
      .reset_pe    (reset_pe),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .start       (start),
      .base_addr   (base_addr),
      .core_reset  (core_reset),
      .kernel_busy (kernel_busy),
      .busy        (busy)
   );

   core_reset_seq u_seq (
      .clk        (clk),
      .reset_pe   (reset_pe),
      .start      (start),
      .core_reset (core_reset),
      .run        (run)
   );

   incr_kernel u_kernel (
      .clk         (clk),
      .reset_pe    (reset_pe),
      .core_reset  (core_reset),
      .run         (run),
      .mem         (mem_bus),
      .kernel_busy (kernel_busy)
   );

   axi_reloc_bridge u_bridge (
      .clk       (clk),
      .reset_pe  (reset_pe),
      .base_addr (base_addr),
      .mem       (mem_bus),
      .awvalid   (awvalid),
      .awaddr    (awaddr),
      .wvalid    (wvalid),
      .wdata     (wdata),
      .bready    (bready),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .rready    (rready),
      .awready   (awready),
      .wready    (wready),
      .bvalid    (bvalid),
      .arready   (arready),
      .rvalid    (rvalid),
      .rdata     (rdata)
   );

endmodule

/* tests/axi_mem_model.sv */
//////////////////////////////////////////////////////////////////////
// AXI slave memory model
// Single-beat reads and writes with random ready and response stalls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axi_mem_model
   import shell_pkg::*;
(
   input  logic                clk,
   input  logic                reset_pe,
   input  logic                awvalid,
   input  logic [ADDR_W-1:0]   awaddr,
   output logic                awready,
   input  logic                wvalid,
   input  logic [DATA_W-1:0]   wdata,
   output logic                wready,
   output logic                bvalid,
   output logic [1:0]          bresp,
   output logic [AXI_ID_W-1:0] bid,
   input  logic                bready,
   input  logic                arvalid,
   input  logic [ADDR_W-1:0]   araddr,
   output logic                arready,
   output logic                rvalid,
   output logic [DATA_W-1:0]   rdata,
   output logic [1:0]          rresp,
   output logic                rlast,
   output logic [AXI_ID_W-1:0] rid,
   input  logic                rready
);

   localparam int          MEM_WORDS = 4096;   // Byte address bits 13:2
   localparam logic [31:0] SEED      = 32'h9aba_50b0;

   logic [DATA_W-1:0] mem [MEM_WORDS];
   int                write_count;
   logic              aw_got;
   logic              w_got;
   logic              ar_got;
   logic [ADDR_W-1:0] aw_q;
   logic [ADDR_W-1:0] ar_q;
   logic [DATA_W-1:0] w_q;

   assign bresp = 2'b00;   // Always OKAY
   assign rresp = 2'b00;
   assign bid   = '0;
   assign rid   = '0;
   assign rlast = 1'b1;

   // Random contents, mixed with the byte address
   initial begin
      void'($urandom(SEED));
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = $urandom() ^ 32'(i * 4);
   end

   always @(posedge clk) begin
      if (reset_pe) begin
         awready     <= 1'b0;
         wready      <= 1'b0;
         arready     <= 1'b0;
         bvalid      <= 1'b0;
         rvalid      <= 1'b0;
         aw_got      <= 1'b0;
         w_got       <= 1'b0;
         ar_got      <= 1'b0;
         write_count <= 0;
      end else begin
         // Ready stalls about one cycle in four
         awready <= ($urandom_range(3, 0) != 0);
         wready  <= ($urandom_range(3, 0) != 0);
         arready <= ($urandom_range(3, 0) != 0);

         if (awvalid && awready) begin
            aw_q   <= awaddr;
            aw_got <= 1'b1;
         end
         if (wvalid && wready) begin
            w_q   <= wdata;
            w_got <= 1'b1;
         end
         if (aw_got && w_got && !bvalid && $urandom_range(1, 0) == 1) begin
            mem[aw_q[13:2]] <= w_q;
            write_count     <= write_count + 1;
            aw_got          <= 1'b0;
            w_got           <= 1'b0;
            bvalid          <= 1'b1;
         end
         if (bvalid && bready)
            bvalid <= 1'b0;

         if (arvalid && arready) begin
            ar_q   <= araddr;
            ar_got <= 1'b1;
         end
         if (ar_got && !rvalid && $urandom_range(1, 0) == 1) begin
            rdata  <= mem[ar_q[13:2]];
            rvalid <= 1'b1;
            ar_got <= 1'b0;
         end
         if (rvalid && rready)
            rvalid <= 1'b0;
      end
   end

endmodule

/* tests/tb_shell.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator shell testbench
// APB setup, two kernel runs against a stalling AXI memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_shell
   import shell_pkg::*;
();

   localparam int                CLK_PERIOD   = 100;
   localparam int                RUN_CYCLES   = 40 * (RESET_DELAY + 20 * WORD_COUNT);
   localparam int                WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;
   localparam logic [7:0]        REG_UNMAPPED = 8'h60;
   localparam logic [ADDR_W-1:0] BASE_A       = 32'h0000_1000;
   localparam logic [ADDR_W-1:0] BASE_B       = 32'h0000_2800;

   logic                 clk = 1'b0;
   logic                 reset_pe;
   logic                 psel, penable, pwrite;
   logic [ADDR_W-1:0]    paddr;
   logic [DATA_W-1:0]    pwdata, prdata;
   logic                 pready, pslverr, busy;
   logic                 awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   logic                 arvalid, arready, rvalid, rready, rlast;
   logic [ADDR_W-1:0]    awaddr, araddr;
   logic [DATA_W-1:0]    wdata, rdata;
   logic [STRB_W-1:0]    wstrb;
   logic [AXI_ID_W-1:0]  awid, arid, bid, rid;
   logic [AXI_LEN_W-1:0] awlen, arlen;
   logic [2:0]           awsize, arsize;
   logic [1:0]           awburst, arburst, bresp, rresp;

   // Expected relocation state for the current run
   logic [ADDR_W-1:0] cur_base;
   int                ar_total, aw_total;
   int                ar_start, aw_start, wc_start;
   int                errors, tests_ok, tests_bad;

   always #(CLK_PERIOD / 2) clk = ~clk;

   shell_top u_dut (.*);

   axi_mem_model u_mem (.*);

   always @(posedge clk) begin
      if (reset_pe) begin
         ar_total <= 0;
         aw_total <= 0;
      end else begin
         if (arvalid && arready) ar_total <= ar_total + 1;   // One per word
         if (awvalid && awready) aw_total <= aw_total + 1;
      end
   end

   task automatic report_error(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Checks on the AXI side
   ///////////////////////////////////////////////////////////////////////

   a_ar_reloc : assert property (@(posedge clk) disable iff (reset_pe)
      arvalid |-> araddr == cur_base + ADDR_W'(4 * (ar_total - ar_start)))
      else report_error($sformatf("araddr %h off the relocated word address", araddr));

   a_aw_reloc : assert property (@(posedge clk) disable iff (reset_pe)
      awvalid |-> awaddr == cur_base + OUT_OFFSET + ADDR_W'(4 * (aw_total - aw_start)))
      else report_error($sformatf("awaddr %h off the relocated output address", awaddr));

   a_ar_hold : assert property (@(posedge clk) disable iff (reset_pe)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else report_error("arvalid or araddr changed before arready");

   a_aw_hold : assert property (@(posedge clk) disable iff (reset_pe)
      awvalid && !awready |=> awvalid && $stable(awaddr))
      else report_error("awvalid or awaddr changed before awready");

   a_w_hold : assert property (@(posedge clk) disable iff (reset_pe)
      wvalid && !wready |=> wvalid && $stable(wdata))
      else report_error("wvalid or wdata changed before wready");

   // Core held in reset means a quiet bus
   a_quiet_hold : assert property (@(posedge clk) disable iff (reset_pe)
      u_dut.u_seq.state == HOLD |-> !arvalid && !awvalid && !wvalid)
      else report_error("AXI valid raised while the core is held in reset");

   // Single beat, id zero, four bytes, INCR, full strobes
   a_aw_attr : assert property (@(posedge clk) disable iff (reset_pe)
      awvalid |-> awid == '0 && awlen == '0 && awsize == 3'b010 && awburst == 2'b01)
      else report_error("AW attributes are not a single four-byte INCR beat");

   a_ar_attr : assert property (@(posedge clk) disable iff (reset_pe)
      arvalid |-> arid == '0 && arlen == '0 && arsize == 3'b010 && arburst == 2'b01)
      else report_error("AR attributes are not a single four-byte INCR beat");

   a_w_attr : assert property (@(posedge clk) disable iff (reset_pe)
      wvalid |-> wstrb == '1 && wlast)
      else report_error("W beat without full strobes or wlast");

   a_pready : assert property (@(posedge clk) disable iff (reset_pe) pready)
      else report_error("pready low");

   ///////////////////////////////////////////////////////////////////////
   // APB access and run helpers
   ///////////////////////////////////////////////////////////////////////

   task automatic apb_write(input logic [7:0] off, input logic [DATA_W-1:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = ADDR_W'(off);
      pwdata  = data;
      @(posedge clk);
      #1 penable = 1'b1;
      @(posedge clk);   // Write lands here
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] off, output logic [DATA_W-1:0] data,
                           output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = ADDR_W'(off);
      @(posedge clk);
      #1 penable = 1'b1;
      @(negedge clk);   // Mid access phase
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Skips the one idle cycle between reset release and the first read
   task automatic wait_idle();
      int low_cycles;
      low_cycles = 0;
      while (low_cycles < 3) begin
         @(negedge clk);
         if (busy) low_cycles = 0;
         else      low_cycles++;
      end
   endtask

   task automatic mark_run(input logic [ADDR_W-1:0] base);
      cur_base = base;
      ar_start = ar_total;
      aw_start = aw_total;
      wc_start = u_mem.write_count;
   endtask

   task automatic check_counts();
      assert (ar_total - ar_start == WORD_COUNT) else
         report_error($sformatf("%0d reads issued, expected %0d",
                                ar_total - ar_start, WORD_COUNT));
      assert (aw_total - aw_start == WORD_COUNT) else
         report_error($sformatf("%0d write addresses issued, expected %0d",
                                aw_total - aw_start, WORD_COUNT));
   endtask

   task automatic check_region(input logic [ADDR_W-1:0] base);
      logic [ADDR_W-1:0] src_a;
      logic [ADDR_W-1:0] dst_a;
      logic [DATA_W-1:0] expected;
      for (int i = 0; i < WORD_COUNT; i++) begin
         src_a    = base + ADDR_W'(4 * i);
         dst_a    = src_a + OUT_OFFSET;
         expected = u_mem.mem[src_a[13:2]] + 32'd1;
         assert (u_mem.mem[dst_a[13:2]] == expected) else
            report_error($sformatf("word %0d at %h is %h, expected %h",
                                   i, dst_a, u_mem.mem[dst_a[13:2]], expected));
      end
      assert (u_mem.write_count - wc_start == WORD_COUNT) else
         report_error($sformatf("%0d writes stored, expected %0d",
                                u_mem.write_count - wc_start, WORD_COUNT));
   endtask

   task automatic end_test(input string name, input int err_mark);
      if (errors == err_mark) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Test sequence
   ///////////////////////////////////////////////////////////////////////

   initial begin
      logic [DATA_W-1:0] rd;
      logic              err;
      int                err_mark;
      reset_pe  = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      errors    = 0;
      tests_ok  = 0;
      tests_bad = 0;
      cur_base  = '0;
      ar_start  = 0;
      aw_start  = 0;
      wc_start  = 0;
      repeat (10) @(posedge clk);
      #1 reset_pe = 1'b0;

      err_mark = errors;
      apb_read(REG_BASE, rd, err);
      assert (rd == '0 && !err) else report_error($sformatf("base reads %h after reset", rd));
      apb_write(REG_BASE, BASE_A);
      apb_read(REG_BASE, rd, err);
      assert (rd == BASE_A) else report_error($sformatf("base reads %h, expected %h", rd, BASE_A));
      apb_read(REG_UNMAPPED, rd, err);
      assert (err) else report_error("pslverr low on an unmapped offset");
      end_test("register access", err_mark);

      err_mark = errors;
      mark_run(BASE_A);
      apb_write(REG_START, 32'd1);
      @(posedge clk);   // Core reset rises one cycle after start
      #1;
      apb_read(REG_BUSY, rd, err);
      assert (rd == 32'd1) else report_error($sformatf("busy reads %h during hold", rd));
      end_test("reset hold", err_mark);

      err_mark = errors;
      wait_idle();
      check_counts();
      end_test("relocation", err_mark);

      err_mark = errors;
      check_region(BASE_A);
      end_test("kernel result", err_mark);

      // Second run at a new region
      err_mark = errors;
      apb_write(REG_START, 32'd0);
      apb_write(REG_BASE, BASE_B);
      mark_run(BASE_B);
      apb_write(REG_START, 32'd1);
      @(posedge clk);
      #1;
      apb_read(REG_BUSY, rd, err);
      assert (rd == 32'd1) else report_error($sformatf("busy reads %h on rerun", rd));
      wait_idle();
      check_counts();
      check_region(BASE_B);
      end_test("back-pressure and rerun", err_mark);

      $display("tests %0d, ok %0d, failed %0d, errors %0d",
               tests_ok + tests_bad, tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the kernel runs did not finish within %0d cycles", 2 * RUN_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* vlog.f */
source/shell_pkg.sv
source/mem_req_if.sv
source/apb_cfg_regs.sv
source/core_reset_seq.sv
source/incr_kernel.sv
source/axi_reloc_bridge.sv
source/shell_top.sv
tests/axi_mem_model.sv
tests/tb_shell.sv
